// ==== verilog/OdsPkg.sv ====
// Shared register map, bus widths and host write-port type for the board controller
package OdsPkg;

    //----------------------------------------------------------------------
    // Host register port widths
    //----------------------------------------------------------------------
    localparam int RegAddrW = 8;                // Register address bits
    localparam int RegDataW = 8;                // Register data bits

    //----------------------------------------------------------------------
    // Register map
    //----------------------------------------------------------------------
    localparam logic [RegAddrW-1:0] BiosWdAddr  = 8'h40;   // BIOS watchdog reload/stop
    localparam logic [RegAddrW-1:0] BiosSelAddr = 8'h41;   // BIOS flash select, bit 0

    //----------------------------------------------------------------------
    // Strobe and board constants
    //----------------------------------------------------------------------
    // One slow tick every SlowPerTick ticks; the watchdog and
    // the reset-hold timer both count in slow ticks
    localparam int SlowPerTick = 16;

    localparam int BiosCount = 2;               // Number of SPI flash devices

    //----------------------------------------------------------------------
    // Host write port
    //----------------------------------------------------------------------
    // One write per cycle when valid is set, no back-pressure
    typedef struct packed {
        logic                valid;             // Write strobe
        logic [RegAddrW-1:0] addr;              // Register address
        logic [RegDataW-1:0] data;              // Write data
    } regWrite_t;

endpackage

// ==== verilog/StrobeGen.sv ====
// Strobe generator, divides the 32 kHz clock into a tick and a slow tick
`timescale 1ns/10ps

module StrobeGen #(
    parameter int TickDiv = 33                  // Clocks per tick
) (
    input  logic CLK32768,                      // Slow oscillator clock
    input  logic rst,                           // Sync reset, active high
    output logic tick,                          // One clock every TickDiv clocks
    output logic slowTick                       // With every SlowPerTick-th tick
);

    localparam int DivW  = $clog2(TickDiv + 1);
    localparam int SlowW = $clog2(OdsPkg::SlowPerTick + 1);

    logic [DivW-1:0]  divCnt;                   // Clock divider
    logic [SlowW-1:0] slowCnt;                  // Tick divider
    logic             divWrap;                  // Last clock of a tick period
    logic             slowWrap;                 // Last tick of a slow period

    assign divWrap  = (divCnt == DivW'(TickDiv - 1));
    assign slowWrap = (slowCnt == SlowW'(OdsPkg::SlowPerTick - 1));

    //----------------------------------------------------------------------
    // Divider chain
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (rst) begin
            divCnt   <= '0;
            slowCnt  <= '0;
            tick     <= 1'b0;
            slowTick <= 1'b0;
        end else begin
            tick     <= divWrap;                // Registered, first after TickDiv clocks
            slowTick <= divWrap && slowWrap;    // Coincides with a tick
            if (divWrap) begin
                divCnt  <= '0;
                slowCnt <= slowWrap ? '0 : slowCnt + 1'b1;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/Debounce.sv ====
// Button debouncer, samples an active-low input on each tick
`timescale 1ns/10ps

module Debounce #(
    parameter int DebounceTicks = 16            // Equal samples needed to flip
) (
    input  logic CLK32768,                      // Slow oscillator clock
    input  logic rst,                           // Sync reset, active high
    input  logic tick,                          // Sample strobe
    input  logic rawN,                          // Raw button, low when pressed
    output logic cleanN                         // Debounced button
);

    localparam int CntW = $clog2(DebounceTicks + 1);

    logic [CntW-1:0] diffCnt;                   // Consecutive differing samples
    logic            differ;                    // Sample disagrees with output
    logic            settled;                   // Enough samples to accept

    assign differ  = (rawN != cleanN);
    assign settled = (diffCnt == CntW'(DebounceTicks - 1));

    //----------------------------------------------------------------------
    // Sample counter and output flop
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (rst) begin
            diffCnt <= '0;
            cleanN  <= 1'b1;                    // Released after reset
        end else if (tick) begin
            if (!differ) begin
                diffCnt <= '0;                  // Bounce back, start over
            end else if (settled) begin
                diffCnt <= '0;
                cleanN  <= rawN;                // Accept new level
            end else begin
                diffCnt <= diffCnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/ButtonControl.sv ====
// Power and reset button conditioning with long-hold BIOS reselect detection
`timescale 1ns/10ps

module ButtonControl #(
    parameter int DebounceTicks = 16,           // Passed to both debouncers
    parameter int HoldTicks     = 32            // Slow ticks for a long press
) (
    input  logic CLK32768,                      // Slow oscillator clock
    input  logic rst,                           // Sync reset, active high
    input  logic tick,                          // Debounce sample strobe
    input  logic slowTick,                      // Hold timer strobe
    input  logic pwrBtnInN,                     // Raw power button
    input  logic sysRstInN,                     // Raw reset button
    output logic sysPwrBtnN,                    // Debounced power button to SIO
    output logic pchRstBtnN,                    // Debounced reset button to PCH
    output logic rstBiosFlg                     // Long press, return to flash 0
);

    localparam int HoldW = $clog2(HoldTicks + 1);

    logic [HoldW-1:0] holdCnt;                  // Press length in slow ticks
    logic             holdDone;                 // Pulse already sent this press
    logic             holdHit;

    //----------------------------------------------------------------------
    // Debouncers
    //----------------------------------------------------------------------
    Debounce #(
        .DebounceTicks(DebounceTicks)
    ) uPwrDeb (
        .CLK32768(CLK32768),
        .rst     (rst),
        .tick    (tick),
        .rawN    (pwrBtnInN),
        .cleanN  (sysPwrBtnN)
    );

    Debounce #(
        .DebounceTicks(DebounceTicks)
    ) uRstDeb (
        .CLK32768(CLK32768),
        .rst     (rst),
        .tick    (tick),
        .rawN    (sysRstInN),
        .cleanN  (pchRstBtnN)
    );

    //----------------------------------------------------------------------
    // Long-hold detection on the reset button
    //----------------------------------------------------------------------
    assign holdHit = (holdCnt == HoldW'(HoldTicks));

    always_ff @(posedge CLK32768) begin
        if (rst || pchRstBtnN) begin            // Release rearms the one-shot
            holdCnt    <= '0;
            holdDone   <= 1'b0;
            rstBiosFlg <= 1'b0;
        end else begin
            rstBiosFlg <= 1'b0;
            if (slowTick && !holdHit) begin
                holdCnt <= holdCnt + 1'b1;      // Saturates at HoldTicks
            end
            if (holdHit && !holdDone) begin
                rstBiosFlg <= 1'b1;             // Once per press
                holdDone   <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/BiosWatchDog.sv ====
// BIOS boot watchdog, forces a flash swap and power-off when POST never finishes
`timescale 1ns/10ps

module BiosWatchDog (
    input  logic              CLK32768,         // Slow oscillator clock
    input  logic              rst,              // Sync reset, active high
    input  logic              slowTick,         // Countdown strobe
    input  OdsPkg::regWrite_t regWr,            // Host register write
    output logic              forceSwap,        // Expiry pulse, one clock
    output logic              biosPowerOff,     // Expired, power-off request
    output logic              biosFinished      // BIOS reported boot done
);

    logic [OdsPkg::RegDataW-1:0] wdCnt;         // Remaining slow ticks
    logic                        armed;         // Countdown running
    logic                        wdWr;          // Write hits our register
    logic                        wdStop;        // Data 0, boot finished
    logic                        expire;        // Last slow tick of countdown

    assign wdWr   = regWr.valid && (regWr.addr == OdsPkg::BiosWdAddr);
    assign wdStop = (regWr.data == '0);
    assign expire = armed && slowTick && (wdCnt == OdsPkg::RegDataW'(1));

    //----------------------------------------------------------------------
    // Control flags
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (rst) begin
            armed        <= 1'b0;
            forceSwap    <= 1'b0;
            biosPowerOff <= 1'b0;
            biosFinished <= 1'b0;
        end else begin
            forceSwap <= 1'b0;
            if (wdWr && wdStop) begin
                armed        <= 1'b0;           // Disarm, keep power-off as is
                biosFinished <= 1'b1;
            end else if (wdWr) begin
                armed        <= 1'b1;           // Reload and arm
                biosFinished <= 1'b0;
                biosPowerOff <= 1'b0;
            end else if (expire) begin
                armed        <= 1'b0;
                forceSwap    <= 1'b1;           // Try the other flash
                biosPowerOff <= 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Down-counter
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (wdWr) begin
            wdCnt <= regWr.data;                // Timeout in slow ticks
        end else if (armed && slowTick) begin
            wdCnt <= wdCnt - 1'b1;
        end
    end

endmodule

// ==== verilog/BiosControl.sv ====
// Dual-BIOS flash selection and SPI chip-select steering with selection LEDs
`timescale 1ns/10ps

module BiosControl (
    input  logic                          CLK32768,   // Slow oscillator clock
    input  logic                          rst,        // Sync reset, active high
    input  logic                          biosSel,    // Jumper, flash after reset
    input  logic                          spiPchCsN,  // PCH SPI chip select
    input  logic                          forceSwap,  // Watchdog expiry
    input  logic                          rstBiosFlg, // Long reset press
    input  OdsPkg::regWrite_t             regWr,      // Host register write
    output logic [OdsPkg::BiosCount-1:0]  biosCsN,    // Per-flash chip selects
    output logic [OdsPkg::BiosCount-1:0]  biosLedN    // Per-flash LEDs, low lit
);

    logic                         curFlash;   // Currently selected flash
    logic                         selWr;      // Write to select register
    logic [OdsPkg::BiosCount-1:0] selDec;     // One-hot of curFlash

    assign selWr = regWr.valid && (regWr.addr == OdsPkg::BiosSelAddr);

    //----------------------------------------------------------------------
    // Current flash register
    //----------------------------------------------------------------------
    always_ff @(posedge CLK32768) begin
        if (rst) begin
            curFlash <= biosSel;              // Jumper decides boot flash
        end else if (rstBiosFlg) begin
            curFlash <= 1'b0;                 // Long press wins over all
        end else if (forceSwap) begin
            curFlash <= ~curFlash;
        end else if (selWr) begin
            curFlash <= regWr.data[0];
        end
    end

    //----------------------------------------------------------------------
    // Chip-select and LED steering
    //----------------------------------------------------------------------
    always_comb begin
        selDec           = '0;
        selDec[curFlash] = 1'b1;
    end

    // Unselected flash held high, selected one follows the PCH
    assign biosCsN  = ~selDec | {OdsPkg::BiosCount{spiPchCsN}};
    assign biosLedN = ~selDec;

endmodule

// ==== verilog/OdsTop.sv ====
// Board controller top level, strobes, buttons, BIOS watchdog and dual-BIOS control
`timescale 1ns/10ps

module OdsTop #(
    parameter int TickDiv       = 33,           // Clocks per tick
    parameter int DebounceTicks = 16,           // Ticks to accept a button level
    parameter int HoldTicks     = 32            // Slow ticks for a long reset press
) (
    input  logic                         CLK32768,      // 32.768 kHz clock
    input  logic                         rst,           // Sync reset, active high
    input  logic                         pwrBtnInN,     // Power button
    input  logic                         sysRstInN,     // Reset button
    input  logic                         spiPchCsN,     // BIOS chip select from PCH
    input  logic                         biosSel,       // BIOS select jumper
    input  OdsPkg::regWrite_t            regWr,         // Host register write port
    output logic                         sysPwrBtnN,    // Power button to SIO
    output logic                         pchRstBtnN,    // Reset button to PCH
    output logic [OdsPkg::BiosCount-1:0] biosCsN,       // SPI flash chip selects
    output logic [OdsPkg::BiosCount-1:0] biosLedN,      // Current BIOS LEDs
    output logic                         biosPowerOff,  // Watchdog power-off request
    output logic                         biosFinished   // BIOS boot complete
);

    logic tick;                                 // Debounce sample strobe
    logic slowTick;                             // Hold and watchdog strobe
    logic forceSwap;                            // Watchdog expiry pulse
    logic rstBiosFlg;                           // Long reset press pulse

    //----------------------------------------------------------------------
    // Timing strobes
    //----------------------------------------------------------------------
    StrobeGen #(
        .TickDiv(TickDiv)
    ) uStrobeGen (
        .CLK32768(CLK32768),
        .rst     (rst),
        .tick    (tick),
        .slowTick(slowTick)
    );

    //----------------------------------------------------------------------
    // Front-panel buttons
    //----------------------------------------------------------------------
    ButtonControl #(
        .DebounceTicks(DebounceTicks),
        .HoldTicks    (HoldTicks)
    ) uButtonControl (
        .CLK32768  (CLK32768),
        .rst       (rst),
        .tick      (tick),
        .slowTick  (slowTick),
        .pwrBtnInN (pwrBtnInN),
        .sysRstInN (sysRstInN),
        .sysPwrBtnN(sysPwrBtnN),
        .pchRstBtnN(pchRstBtnN),
        .rstBiosFlg(rstBiosFlg)
    );

    //----------------------------------------------------------------------
    // BIOS watchdog and flash steering
    //----------------------------------------------------------------------
    BiosWatchDog uBiosWatchDog (
        .CLK32768    (CLK32768),
        .rst         (rst),
        .slowTick    (slowTick),
        .regWr       (regWr),
        .forceSwap   (forceSwap),
        .biosPowerOff(biosPowerOff),
        .biosFinished(biosFinished)
    );

    BiosControl uBiosControl (
        .CLK32768  (CLK32768),
        .rst       (rst),
        .biosSel   (biosSel),
        .spiPchCsN (spiPchCsN),
        .forceSwap (forceSwap),
        .rstBiosFlg(rstBiosFlg),
        .regWr     (regWr),
        .biosCsN   (biosCsN),
        .biosLedN  (biosLedN)
    );

endmodule

// ==== dv/OdsTb.sv ====
// Testbench for the board controller, checks buttons, BIOS watchdog and flash steering
`timescale 1ns/10ps

module OdsTb;

    localparam int TickDiv       = 4;
    localparam int DebounceTicks = 3;
    localparam int HoldTicks     = 4;
    localparam int SlowClks      = OdsPkg::SlowPerTick * TickDiv;    // Clocks per slow tick
    localparam int BtnLimit      = 2 * (DebounceTicks + 2) * TickDiv;
    localparam int HoldMin       = (HoldTicks - 1) * SlowClks;       // Earliest long-press hit
    localparam int HoldLimit     = (HoldTicks + 2) * SlowClks;
    localparam int WdLimit       = 3 * SlowClks;                     // Two slow ticks plus slack

    logic                             CLK32768;
    logic                             rst;
    logic                             pwrBtnInN;
    logic                             sysRstInN;
    logic                             spiPchCsN;
    logic                             biosSel;
    OdsPkg::regWrite_t                regWr;
    logic                             sysPwrBtnN;
    logic                             pchRstBtnN;
    logic [OdsPkg::BiosCount-1:0]     biosCsN;
    logic [OdsPkg::BiosCount-1:0]     biosLedN;
    logic                             biosPowerOff;
    logic                             biosFinished;

    logic                             modelFlash;   // Expected current flash
    logic                             expFinished;  // Expected boot-done flag
    logic [31:0]                      rngState;
    logic [OdsPkg::RegDataW-1:0]      selData;      // Random select write data
    int                               cnt;          // Wait loop counter
    logic [2*OdsPkg::BiosCount-1:0]   expSteer;     // {csN, ledN} expected

    OdsTop #(
        .TickDiv      (TickDiv),
        .DebounceTicks(DebounceTicks),
        .HoldTicks    (HoldTicks)
    ) uut (
        .CLK32768    (CLK32768),
        .rst         (rst),
        .pwrBtnInN   (pwrBtnInN),
        .sysRstInN   (sysRstInN),
        .spiPchCsN   (spiPchCsN),
        .biosSel     (biosSel),
        .regWr       (regWr),
        .sysPwrBtnN  (sysPwrBtnN),
        .pchRstBtnN  (pchRstBtnN),
        .biosCsN     (biosCsN),
        .biosLedN    (biosLedN),
        .biosPowerOff(biosPowerOff),
        .biosFinished(biosFinished)
    );

    always #10 CLK32768 = ~CLK32768;                // 20 ns period

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected chip selects and LEDs for a given flash and PCH select
    function automatic logic [2*OdsPkg::BiosCount-1:0] refSteering(input logic flash,
                                                                    input logic csN);
        logic [OdsPkg::BiosCount-1:0] cs;
        logic [OdsPkg::BiosCount-1:0] led;
        cs         = '1;                            // Idle flash stays deselected
        led        = '1;
        cs[flash]  = csN;                           // Selected flash follows the PCH
        led[flash] = 1'b0;
        return {cs, led};
    endfunction

    task automatic stopOnFailure(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Simulation stopped after the first error");
    endtask

    task automatic reportErr(input string msg);
        stopOnFailure($sformatf("ERR %0t: %s", $time, msg));
    endtask

    task automatic timeoutFail(input string what);
        stopOnFailure($sformatf("Timeout while waiting for %s", what));
    endtask

    task automatic nextCycle();
        @(posedge CLK32768);
        #2;
        rngState  = xorshift32(rngState);
        spiPchCsN = rngState[0];                    // PCH select changes at random
    endtask

    task automatic writeReg(input logic [OdsPkg::RegAddrW-1:0] addr,
                            input logic [OdsPkg::RegDataW-1:0] data);
        regWr.valid = 1'b1;
        regWr.addr  = addr;
        regWr.data  = data;
        nextCycle();                                // Taken on this edge
        regWr.valid = 1'b0;
    endtask

    //----------------------------------------------------------------------
    // Checking process, mid-cycle when everything is settled
    //----------------------------------------------------------------------
    always @(negedge CLK32768) begin
        if (!rst) begin
            expSteer = refSteering(modelFlash, spiPchCsN);
            assert ({biosCsN, biosLedN} == expSteer)
            else reportErr($sformatf("biosCsN %b biosLedN %b, expected %b",
                                     biosCsN, biosLedN, expSteer));
            assert (biosFinished == expFinished)
            else reportErr($sformatf("biosFinished %b, expected %b", biosFinished, expFinished));
        end
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    initial begin
        CLK32768    = 1'b0;
        rst         = 1'b1;
        pwrBtnInN   = 1'b1;
        sysRstInN   = 1'b1;
        spiPchCsN   = 1'b1;
        biosSel     = 1'b1;                         // Boot from flash 1
        regWr       = '0;
        modelFlash  = 1'b1;
        expFinished = 1'b0;
        selData     = '0;
        rngState    = 32'h4e1b78a2;
        repeat (10) @(posedge CLK32768);
        #2;
        rst = 1'b0;

        // State after reset
        nextCycle();
        assert (biosCsN[0] === 1'b1 && biosLedN === 2'b01)
        else reportErr($sformatf("after reset biosCsN %b biosLedN %b", biosCsN, biosLedN));
        assert (sysPwrBtnN === 1'b1 && pchRstBtnN === 1'b1)
        else reportErr("debounced buttons not high after reset");
        assert (biosPowerOff === 1'b0 && biosFinished === 1'b0)
        else reportErr("watchdog flags not low after reset");

        // Power button, one-tick glitch then a real press
        pwrBtnInN = 1'b0;
        repeat (TickDiv) nextCycle();
        pwrBtnInN = 1'b1;
        repeat (8 * TickDiv) begin
            nextCycle();
            assert (sysPwrBtnN === 1'b1) else reportErr("glitch lowered sysPwrBtnN");
        end
        pwrBtnInN = 1'b0;
        cnt = 0;
        while (sysPwrBtnN !== 1'b0) begin
            nextCycle();
            cnt++;
            if (cnt > BtnLimit) timeoutFail("sysPwrBtnN to go low");
        end
        pwrBtnInN = 1'b1;
        cnt = 0;
        while (sysPwrBtnN !== 1'b1) begin
            nextCycle();
            cnt++;
            if (cnt > BtnLimit) timeoutFail("sysPwrBtnN to go high");
        end

        // Host selects flash through the select register
        repeat (12) begin
            rngState = xorshift32(rngState);
            selData  = rngState[15:8];
            writeReg(OdsPkg::BiosSelAddr, selData);
            modelFlash = selData[0];                // Data bit 0 picks the flash
            repeat (3) nextCycle();
        end

        // Watchdog expiry swaps flash and requests power-off
        writeReg(OdsPkg::BiosWdAddr, 8'd2);
        assert (biosPowerOff === 1'b0) else reportErr("biosPowerOff set on arming");
        cnt = 0;
        while (biosPowerOff !== 1'b1) begin
            nextCycle();
            cnt++;
            if (cnt > WdLimit) timeoutFail("watchdog power-off request");
        end
        nextCycle();
        modelFlash = ~modelFlash;                   // Swap lands one clock after expiry
        repeat (4) nextCycle();
        writeReg(OdsPkg::BiosWdAddr, 8'd0);
        expFinished = 1'b1;
        repeat (2 * SlowClks) begin
            nextCycle();
            assert (biosPowerOff === 1'b1) else reportErr("boot-done write cleared power-off");
        end

        // Long reset press returns to flash 0, once per press
        repeat (2) begin
            writeReg(OdsPkg::BiosSelAddr, 8'h01);
            modelFlash = 1'b1;
            sysRstInN  = 1'b0;
            cnt = 0;
            while (biosLedN !== 2'b10) begin
                nextCycle();
                cnt++;
                if (cnt > HoldLimit) timeoutFail("long press to select flash 0");
            end
            modelFlash = 1'b0;
            assert (cnt >= HoldMin)
            else reportErr($sformatf("flash 0 selected after %0d clocks, too early", cnt));
            assert (pchRstBtnN === 1'b0) else reportErr("pchRstBtnN not low while held");
            writeReg(OdsPkg::BiosSelAddr, 8'h01);   // Second pulse would undo this
            modelFlash = 1'b1;
            repeat ((HoldTicks + 1) * SlowClks) nextCycle();
            sysRstInN = 1'b1;
            cnt = 0;
            while (pchRstBtnN !== 1'b1) begin
                nextCycle();
                cnt++;
                if (cnt > BtnLimit) timeoutFail("pchRstBtnN to go high");
            end
            repeat (4) nextCycle();
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/OdsPkg.sv
verilog/StrobeGen.sv
verilog/Debounce.sv
verilog/ButtonControl.sv
verilog/BiosWatchDog.sv
verilog/BiosControl.sv
verilog/OdsTop.sv
dv/OdsTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status reflects the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module OdsTb -f flist.f \
    --Mdir obj_dir -o OdsTbSim \
    && ./obj_dir/OdsTbSim \
    || { echo "Simulation build or run ended with an error"; exit 1; }

exit 0
